/* hw/rv_pipe_pkg.sv */
// Shared widths, encodings and control types of the rv_pipe core
package rv_pipe_pkg;

    // Datapath and register index widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // RV32I major opcodes in use
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_imm    = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_system = 7'b1110011
    } opcode_e;

    // ALU operation field
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_slt = 4'd5
    } alu_op_e;

    // Decoded control, carried down the pipeline
    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    alu_src;
        logic    halt;
        alu_op_e alu_op;
    } ctrl_t;

    // EX operand source
    typedef enum logic [1:0] {
        fwd_rf  = 2'd0,
        fwd_mem = 2'd1,
        fwd_wb  = 2'd2
    } fwd_e;

endpackage

/* hw/mem_bus.sv */
// Word-wide memory access port between the core and a RAM
`timescale 1ns/10ps
interface mem_bus;
    import rv_pipe_pkg::*;

    // Byte address, low two bits ignored by the RAM
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic            we;
    logic            re;
    // Valid one cycle after addr with re
    logic [xlen-1:0] rdata;

    modport core (output addr, output wdata, output we, output re, input rdata);
    modport mem (input addr, input wdata, input we, input re, output rdata);

endinterface

/* hw/word_ram.sv */
// Word RAM with one synchronous access port and a preload port
`timescale 1ns/10ps
module word_ram #(
    parameter int words = 256
) (
    input  logic                         clk,
    mem_bus.mem                          bus,
    input  logic                         load_we,
    input  logic [rv_pipe_pkg::xlen-1:0] load_addr,
    input  logic [rv_pipe_pkg::xlen-1:0] load_data
);
    import rv_pipe_pkg::*;

    localparam int aw = $clog2(words);

    logic [xlen-1:0] mem [words];
    logic [aw-1:0]   idx;
    logic [aw-1:0]   load_idx;

    // Byte address to word index
    assign idx      = bus.addr[aw+1:2];
    assign load_idx = load_addr[aw+1:2];

    always_ff @(posedge clk) begin
        // Preload wins over the access port
        if (load_we) begin
            mem[load_idx] <= load_data;
        end else if (bus.we) begin
            mem[idx] <= bus.wdata;
        end
        // Read data holds while re is low
        if (bus.re) begin
            bus.rdata <= mem[idx];
        end
    end

endmodule

/* hw/regfile.sv */
// Register file, 32 x 32 bits, two read ports with write-through
`timescale 1ns/10ps
module regfile (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [rv_pipe_pkg::reg_addr_w-1:0] ra1,
    input  logic [rv_pipe_pkg::reg_addr_w-1:0] ra2,
    output logic [rv_pipe_pkg::xlen-1:0]       rd1,
    output logic [rv_pipe_pkg::xlen-1:0]       rd2,
    input  logic                               we,
    input  logic [rv_pipe_pkg::reg_addr_w-1:0] wa,
    input  logic [rv_pipe_pkg::xlen-1:0]       wd
);
    import rv_pipe_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];
    logic            wr_en;

    // x0 is never written
    assign wr_en = we && (wa != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wa] <= wd;
        end
    end

    // Bypass the value being written back this cycle
    assign rd1 = (wr_en && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (wr_en && wa == ra2) ? wd : regs[ra2];

endmodule

/* hw/decoder.sv */
// ID stage control unit and immediate generator
`timescale 1ns/10ps
module decoder (
    input  logic [rv_pipe_pkg::xlen-1:0]       instr,
    output rv_pipe_pkg::ctrl_t                 ctrl,
    output logic [rv_pipe_pkg::xlen-1:0]       imm,
    output logic [rv_pipe_pkg::reg_addr_w-1:0] rs1,
    output logic [rv_pipe_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_pipe_pkg::reg_addr_w-1:0] rd
);
    import rv_pipe_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;
    logic       use_rs1;
    logic       use_rs2;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    // Unused sources read as x0 so they never forward or stall
    assign rs1    = use_rs1 ? instr[19:15] : '0;
    assign rs2    = use_rs2 ? instr[24:20] : '0;

    always_comb begin
        ctrl    = '0;
        imm     = '0;
        legal   = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b0;
        case (instr[6:0])
            opc_op: begin
                use_rs2        = 1'b1;
                ctrl.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: ctrl.alu_op = alu_add;
                    {7'h20, 3'b000}: ctrl.alu_op = alu_sub;
                    {7'h00, 3'b111}: ctrl.alu_op = alu_and;
                    {7'h00, 3'b110}: ctrl.alu_op = alu_or;
                    {7'h00, 3'b100}: ctrl.alu_op = alu_xor;
                    {7'h00, 3'b010}: ctrl.alu_op = alu_slt;
                    default:         legal = 1'b0;
                endcase
            end
            // ADDI only
            opc_imm: begin
                legal          = (funct3 == 3'b000);
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:20]};
            end
            // LW only
            opc_load: begin
                legal           = (funct3 == 3'b010);
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.alu_src    = 1'b1;
                imm             = {{20{instr[31]}}, instr[31:20]};
            end
            // SW only
            opc_store: begin
                legal          = (funct3 == 3'b010);
                use_rs2        = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            // BEQ only, compared by subtraction
            opc_branch: begin
                legal       = (funct3 == 3'b000);
                use_rs2     = 1'b1;
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_sub;
                imm         = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                               instr[11:8], 1'b0};
            end
            // ECALL as halt
            opc_system: begin
                legal     = (instr[31:7] == '0);
                use_rs1   = 1'b0;
                ctrl.halt = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        // Anything else becomes a bubble
        if (!legal) begin
            ctrl    = '0;
            use_rs1 = 1'b0;
            use_rs2 = 1'b0;
        end
    end

endmodule

/* hw/alu.sv */
// 32-bit ALU with zero, negative, overflow and carry flags
`timescale 1ns/10ps
module alu (
    input  logic [rv_pipe_pkg::xlen-1:0] a,
    input  logic [rv_pipe_pkg::xlen-1:0] b,
    input  rv_pipe_pkg::alu_op_e          op,
    output logic [rv_pipe_pkg::xlen-1:0] y,
    output logic [3:0]                    flags
);
    import rv_pipe_pkg::*;

    logic            do_sub;
    logic [xlen-1:0] b_in;
    logic [xlen:0]   sum;
    logic            ovf;

    // Shared adder, SLT compares through a - b
    assign do_sub = (op == alu_sub) || (op == alu_slt);
    assign b_in   = do_sub ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, b_in} + {{xlen{1'b0}}, do_sub};
    assign ovf    = (a[xlen-1] == b_in[xlen-1]) && (sum[xlen-1] != a[xlen-1]);

    always_comb begin
        case (op)
            alu_add, alu_sub: y = sum[xlen-1:0];
            alu_and:          y = a & b;
            alu_or:           y = a | b;
            alu_xor:          y = a ^ b;
            alu_slt:          y = {{(xlen-1){1'b0}}, sum[xlen-1] ^ ovf};
            default:          y = '0;
        endcase
    end

    // Order {zero, negative, overflow, carry}
    assign flags = {(y == '0), y[xlen-1], ovf, sum[xlen]};

endmodule

/* hw/hazard_unit.sv */
// Forwarding selects, load-use stall and branch flush
`timescale 1ns/10ps
module hazard_unit (
    input  logic [rv_pipe_pkg::reg_addr_w-1:0] id_rs1,
    input  logic [rv_pipe_pkg::reg_addr_w-1:0] id_rs2,
    input  logic [rv_pipe_pkg::reg_addr_w-1:0] ex_rs1,
    input  logic [rv_pipe_pkg::reg_addr_w-1:0] ex_rs2,
    input  logic [rv_pipe_pkg::reg_addr_w-1:0] ex_rd,
    input  logic                               ex_mem_read,
    input  logic [rv_pipe_pkg::reg_addr_w-1:0] mem_rd,
    input  logic                               mem_reg_write,
    input  logic [rv_pipe_pkg::reg_addr_w-1:0] wb_rd,
    input  logic                               wb_reg_write,
    input  logic                               branch_taken,
    output rv_pipe_pkg::fwd_e                  fwd_a,
    output rv_pipe_pkg::fwd_e                  fwd_b,
    output logic                               stall,
    output logic                               flush
);
    import rv_pipe_pkg::*;

    logic load_use;

    // Youngest nonzero producer wins
    function automatic fwd_e pick(input logic [reg_addr_w-1:0] src);
        if (src != '0 && mem_reg_write && mem_rd == src) return fwd_mem;
        if (src != '0 && wb_reg_write && wb_rd == src) return fwd_wb;
        return fwd_rf;
    endfunction

    always_comb begin
        fwd_a = pick(ex_rs1);
        fwd_b = pick(ex_rs2);
    end

    // Load in EX feeding the instruction in ID
    assign load_use = ex_mem_read && (ex_rd != '0) &&
                      (ex_rd == id_rs1 || ex_rd == id_rs2);

    // Flush overrides the stall
    assign flush = branch_taken;
    assign stall = load_use && !branch_taken;

endmodule

/* hw/cpu.sv */
// Five-stage RV32I subset pipeline with forwarding, stall and flush
`timescale 1ns/10ps
module cpu (
    input  logic                         clk,
    input  logic                         rst_n,
    mem_bus.core                         imem,
    mem_bus.core                         dmem,
    output logic                         st_valid,
    output logic [rv_pipe_pkg::xlen-1:0] st_addr,
    output logic [rv_pipe_pkg::xlen-1:0] st_data,
    output logic                         halted
);
    import rv_pipe_pkg::*;

    // ------------------------------
    // Pipeline registers
    // ------------------------------
    logic [xlen-1:0]       pc;

    // IF/ID, word arrives from the synchronous fetch
    logic                  ifid_valid;
    logic [xlen-1:0]       ifid_pc;
    logic [xlen-1:0]       ifid_ir;

    // ID/EX
    logic                  idex_valid;
    logic [xlen-1:0]       idex_pc;
    ctrl_t                 idex_ctrl;
    logic [xlen-1:0]       idex_data_read_1;
    logic [xlen-1:0]       idex_data_read_2;
    logic [reg_addr_w-1:0] idex_rs1;
    logic [reg_addr_w-1:0] idex_rs2;
    logic [reg_addr_w-1:0] idex_rd;
    logic [xlen-1:0]       idex_imm;

    // EX/MEM
    logic                  exmem_valid;
    ctrl_t                 exmem_ctrl;
    logic [xlen-1:0]       exmem_branch_target;
    logic [3:0]            exmem_flags;
    logic [xlen-1:0]       exmem_alu_out;
    logic [xlen-1:0]       exmem_data_read_2;
    logic [reg_addr_w-1:0] exmem_rd;

    // MEM/WB, load data arrives from the synchronous dmem read
    logic                  memwb_valid;
    ctrl_t                 memwb_ctrl;
    logic [xlen-1:0]       memwb_mem_data_read;
    logic [xlen-1:0]       memwb_alu_out;
    logic [reg_addr_w-1:0] memwb_rd;

    // Stage wires
    ctrl_t                 dec_ctrl;
    ctrl_t                 id_ctrl;
    ctrl_t                 ex_ctrl;
    ctrl_t                 mem_ctrl;
    ctrl_t                 wb_ctrl;
    logic [xlen-1:0]       id_imm;
    logic [reg_addr_w-1:0] id_rs1;
    logic [reg_addr_w-1:0] id_rs2;
    logic [reg_addr_w-1:0] id_rd;
    logic [xlen-1:0]       rd1;
    logic [xlen-1:0]       rd2;
    fwd_e                  fwd_a;
    fwd_e                  fwd_b;
    logic                  stall;
    logic                  flush;
    logic                  fetch_stop;
    logic                  branch_taken;
    logic [xlen-1:0]       ex_a;
    logic [xlen-1:0]       ex_b_reg;
    logic [xlen-1:0]       alu_y;
    logic [3:0]            alu_flags;
    logic [xlen-1:0]       wb_data;

    // Invalid stages carry no control
    assign id_ctrl  = ifid_valid ? dec_ctrl : '0;
    assign ex_ctrl  = idex_valid ? idex_ctrl : '0;
    assign mem_ctrl = exmem_valid ? exmem_ctrl : '0;
    assign wb_ctrl  = memwb_valid ? memwb_ctrl : '0;

    // ------------------------------
    // IF and ID
    // ------------------------------
    assign imem.addr  = pc;
    assign imem.wdata = '0;
    assign imem.we    = 1'b0;
    // Fetch paused on stall so the ID word holds
    assign imem.re    = !stall && !halted;
    assign ifid_ir    = imem.rdata;

    // No fetch becomes valid behind a halt in flight
    assign fetch_stop = id_ctrl.halt || ex_ctrl.halt || mem_ctrl.halt;

    decoder dec0 (.instr(ifid_ir), .ctrl(dec_ctrl), .imm(id_imm),
                  .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd));

    regfile rf0 (.clk(clk), .rst_n(rst_n), .ra1(id_rs1), .ra2(id_rs2), .rd1(rd1),
                 .rd2(rd2), .we(wb_ctrl.reg_write), .wa(memwb_rd), .wd(wb_data));

    hazard_unit hz0 (.id_rs1(id_rs1), .id_rs2(id_rs2), .ex_rs1(idex_rs1),
                     .ex_rs2(idex_rs2), .ex_rd(idex_rd), .ex_mem_read(ex_ctrl.mem_read),
                     .mem_rd(exmem_rd), .mem_reg_write(mem_ctrl.reg_write),
                     .wb_rd(memwb_rd), .wb_reg_write(wb_ctrl.reg_write),
                     .branch_taken(branch_taken), .fwd_a(fwd_a), .fwd_b(fwd_b),
                     .stall(stall), .flush(flush));

    // ------------------------------
    // EX
    // ------------------------------
    always_comb begin
        case (fwd_a)
            fwd_mem: ex_a = exmem_alu_out;
            fwd_wb:  ex_a = wb_data;
            default: ex_a = idex_data_read_1;
        endcase
        case (fwd_b)
            fwd_mem: ex_b_reg = exmem_alu_out;
            fwd_wb:  ex_b_reg = wb_data;
            default: ex_b_reg = idex_data_read_2;
        endcase
    end

    alu alu0 (.a(ex_a), .b(idex_ctrl.alu_src ? idex_imm : ex_b_reg),
              .op(idex_ctrl.alu_op), .y(alu_y), .flags(alu_flags));

    // ------------------------------
    // MEM and WB
    // ------------------------------
    // BEQ taken on the zero flag
    assign branch_taken = mem_ctrl.branch && exmem_flags[3];

    assign dmem.addr  = exmem_alu_out;
    assign dmem.wdata = exmem_data_read_2;
    assign dmem.we    = mem_ctrl.mem_write;
    assign dmem.re    = mem_ctrl.mem_read;

    assign st_valid = mem_ctrl.mem_write;
    assign st_addr  = exmem_alu_out;
    assign st_data  = exmem_data_read_2;

    assign memwb_mem_data_read = dmem.rdata;
    assign wb_data = wb_ctrl.mem_to_reg ? memwb_mem_data_read : memwb_alu_out;

    // PC, valid bits and halt, all frozen once halted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= '0;
            ifid_valid  <= 1'b0;
            idex_valid  <= 1'b0;
            exmem_valid <= 1'b0;
            memwb_valid <= 1'b0;
            halted      <= 1'b0;
        end else if (!halted) begin
            // Rises as the halt enters WB
            halted <= mem_ctrl.halt;
            if (flush) begin
                pc         <= exmem_branch_target;
                ifid_valid <= 1'b0;
            end else if (!stall) begin
                pc         <= pc + xlen'(4);
                ifid_valid <= !fetch_stop;
            end
            // Stall bubbles ID/EX, flush also squashes the EX result
            idex_valid  <= ifid_valid && !stall && !flush;
            exmem_valid <= idex_valid && !flush;
            memwb_valid <= exmem_valid;
        end
    end

    // Stage payload
    always_ff @(posedge clk) begin
        if (!halted) begin
            if (!stall) begin
                ifid_pc <= pc;
            end
            idex_pc             <= ifid_pc;
            idex_ctrl           <= id_ctrl;
            idex_data_read_1    <= rd1;
            idex_data_read_2    <= rd2;
            idex_rs1            <= id_rs1;
            idex_rs2            <= id_rs2;
            idex_rd             <= id_rd;
            idex_imm            <= id_imm;
            exmem_ctrl          <= idex_ctrl;
            exmem_branch_target <= idex_pc + idex_imm;
            exmem_flags         <= alu_flags;
            exmem_alu_out       <= alu_y;
            exmem_data_read_2   <= ex_b_reg;
            exmem_rd            <= idex_rd;
            memwb_ctrl          <= exmem_ctrl;
            memwb_alu_out       <= exmem_alu_out;
            memwb_rd            <= exmem_rd;
        end
    end

endmodule

/* hw/rv_pipe_top.sv */
// rv_pipe top level, core with instruction and data RAMs
`timescale 1ns/10ps
module rv_pipe_top #(
    parameter int imem_words = 256,
    parameter int dmem_words = 256
) (
    input  logic                         clk,
    input  logic                         rst_n,
    // Preload ports, used while in reset
    input  logic                         imem_load_we,
    input  logic [rv_pipe_pkg::xlen-1:0] imem_load_addr,
    input  logic [rv_pipe_pkg::xlen-1:0] imem_load_data,
    input  logic                         dmem_load_we,
    input  logic [rv_pipe_pkg::xlen-1:0] dmem_load_addr,
    input  logic [rv_pipe_pkg::xlen-1:0] dmem_load_data,
    // Store trace and completion
    output logic                         st_valid,
    output logic [rv_pipe_pkg::xlen-1:0] st_addr,
    output logic [rv_pipe_pkg::xlen-1:0] st_data,
    output logic                         halted
);

    mem_bus imem_bus ();
    mem_bus dmem_bus ();

    cpu cpu0 (.clk(clk), .rst_n(rst_n), .imem(imem_bus.core), .dmem(dmem_bus.core),
              .st_valid(st_valid), .st_addr(st_addr), .st_data(st_data),
              .halted(halted));

    word_ram #(.words(imem_words)) imem0 (.clk(clk), .bus(imem_bus.mem),
        .load_we(imem_load_we), .load_addr(imem_load_addr), .load_data(imem_load_data));

    word_ram #(.words(dmem_words)) dmem0 (.clk(clk), .bus(dmem_bus.mem),
        .load_we(dmem_load_we), .load_addr(dmem_load_addr), .load_data(dmem_load_data));

endmodule

/* tests/rv_pipe_assertions.sv */
// Concurrent checks on the core's pipeline control, bound into cpu
`timescale 1ns/10ps
module rv_pipe_assertions (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         halted,
    input logic                         stall,
    input logic                         flush,
    input logic                         st_valid,
    input logic                         ifid_valid,
    input logic                         idex_valid,
    input logic                         exmem_valid,
    input logic [rv_pipe_pkg::xlen-1:0] pc,
    input logic [rv_pipe_pkg::xlen-1:0] exmem_branch_target
);

    // Once up, halted stays up until reset
    halted_holds: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
        else $error("halted fell without reset");

    // Flush wins over a pending stall
    flush_wins: assert property (@(posedge clk) disable iff (!rst_n)
        flush && !halted |=> pc == $past(exmem_branch_target) && !ifid_valid &&
            !idex_valid && !exmem_valid)
        else $error("flush did not redirect and empty the younger stages");

    // Load-use stall holds the PC and bubbles ID/EX
    stall_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
        stall && !halted |=> pc == $past(pc) && !idex_valid)
        else $error("stall did not hold the PC or bubble ID/EX");

    // No store strobe in reset
    no_store_in_reset: assert property (@(posedge clk) !rst_n |-> !st_valid)
        else $error("st_valid high during reset");

    // Branch in MEM is never a store
    no_store_on_flush: assert property (@(posedge clk) disable iff (!rst_n) flush |-> !st_valid)
        else $error("st_valid high during flush");

endmodule

bind cpu rv_pipe_assertions asrt0 (.*);

/* tests/rv_pipe_tb.sv */
// rv_pipe testbench, random program checked against an instruction-set model
`timescale 1ns/10ps
module rv_pipe_tb;
    import rv_pipe_pkg::*;

    localparam int body_len   = 40;
    localparam int data_words = 64;
    localparam int dump_base  = 512;

    logic        clk;
    logic        rst_n;
    logic        imem_load_we;
    logic [31:0] imem_load_addr;
    logic [31:0] imem_load_data;
    logic        dmem_load_we;
    logic [31:0] dmem_load_addr;
    logic [31:0] dmem_load_data;
    logic        st_valid;
    logic [31:0] st_addr;
    logic [31:0] st_data;
    logic        halted;

    integer      seed;
    logic [31:0] prog [$];
    logic [31:0] init_data [data_words];
    // Program body as fields, kind 0 R-type, 1 ADDI, 2 LW, 3 SW, 4 BEQ
    int          b_kind [body_len];
    int          b_op [body_len];
    int          b_rd [body_len];
    int          b_rs1 [body_len];
    int          b_rs2 [body_len];
    int          b_imm [body_len];
    // Expected store list, with the test each store belongs to
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          exp_test [$];
    string       names [5];
    int          errs [5];
    int          n_taken;
    int          n_not_taken;
    int          icount;
    int          n_stores;
    int          trace_errs;
    int          cur_test;
    int          limit;
    int          cycles;
    int          total;
    int          n_load;

    rv_pipe_top #(.imem_words(256), .dmem_words(256)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int urand(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // RV32I encodings straight from the instruction formats
    function automatic logic [31:0] encode(input int kind, input int op, input int rd,
                                           input int rs1, input int rs2, input int imm);
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [12:0] i13;
        i13 = 13'(imm);
        f7  = (op == 1) ? 7'h20 : 7'h00;
        case (op)
            2:       f3 = 3'b111;
            3:       f3 = 3'b110;
            4:       f3 = 3'b100;
            5:       f3 = 3'b010;
            default: f3 = 3'b000;
        endcase
        case (kind)
            0: return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
            1: return {i13[11:0], 5'(rs1), 3'b000, 5'(rd), 7'h13};
            2: return {i13[11:0], 5'(rs1), 3'b010, 5'(rd), 7'h03};
            3: return {i13[11:5], 5'(rs2), 5'(rs1), 3'b010, i13[4:0], 7'h23};
            4: return {i13[12], i13[10:5], 5'(rs2), 5'(rs1), 3'b000, i13[4:1], i13[11], 7'h63};
            default: return 32'h0000_0073;
        endcase
    endfunction

    task automatic build_program();
        int skip;
        for (int i = 0; i < data_words; i++) begin
            init_data[i] = $random(seed);
        end
        for (int i = 0; i < body_len; i++) begin
            b_kind[i] = urand(5);
            b_op[i]   = urand(6);
            b_rd[i]   = urand(8);
            // Lean on the previous result to build dependent chains
            b_rs1[i]  = (i > 0 && urand(2) == 0) ? b_rd[i-1] : urand(8);
            b_rs2[i]  = urand(8);
            b_imm[i]  = urand(2048) - 1024;
            if (b_kind[i] == 2 || b_kind[i] == 3) begin
                b_rs1[i] = 0;
                b_imm[i] = 4 * urand(data_words);
            end
            // Forward-only branch that stays inside the body
            if (b_kind[i] == 4) begin
                skip = 1 + urand(3);
                if (skip > body_len - 1 - i) begin
                    b_kind[i] = 1;
                end else begin
                    b_imm[i] = (skip + 1) * 4;
                    if (urand(2) == 0) b_rs2[i] = b_rs1[i];
                end
            end
            prog.push_back(encode(b_kind[i], b_op[i], b_rd[i], b_rs1[i], b_rs2[i], b_imm[i]));
        end
        // Dump every register, then halt
        for (int r = 0; r < 32; r++) begin
            prog.push_back(encode(3, 0, 0, 0, r, dump_base + 4 * r));
        end
        prog.push_back(encode(5, 0, 0, 0, 0, 0));
    endtask

    // Instruction-set model, one instruction per step
    task automatic run_model();
        logic [31:0] x [32];
        logic [31:0] dm [256];
        int          writer [32];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        int          pc;
        for (int r = 0; r < 32; r++) begin
            x[r] = '0;
            writer[r] = 0;
        end
        for (int w = 0; w < 256; w++) begin
            dm[w] = (w < data_words) ? init_data[w] : '0;
        end
        pc = 0;
        icount = 0;
        while (pc < body_len) begin
            icount++;
            a = x[b_rs1[pc]];
            b = x[b_rs2[pc]];
            v = '0;
            case (b_kind[pc])
                0: begin
                    case (b_op[pc])
                        0: v = a + b;
                        1: v = a - b;
                        2: v = a & b;
                        3: v = a | b;
                        4: v = a ^ b;
                        default: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    endcase
                end
                1: v = a + 32'(b_imm[pc]);
                2: v = dm[b_imm[pc] / 4];
                3: begin
                    dm[b_imm[pc] / 4] = b;
                    exp_addr.push_back(32'(b_imm[pc]));
                    exp_data.push_back(b);
                    exp_test.push_back(2);
                end
                default: ;
            endcase
            if (b_kind[pc] <= 2 && b_rd[pc] != 0) begin
                x[b_rd[pc]] = v;
                writer[b_rd[pc]] = (b_kind[pc] == 2) ? 2 : 1;
            end
            if (b_kind[pc] == 4 && a == b) begin
                n_taken++;
                pc += b_imm[pc] / 4;
            end else begin
                if (b_kind[pc] == 4) n_not_taken++;
                pc++;
            end
        end
        for (int r = 0; r < 32; r++) begin
            exp_addr.push_back(32'(dump_base + 4 * r));
            exp_data.push_back(x[r]);
            exp_test.push_back(r == 0 ? 4 : (writer[r] == 2 ? 1 : 0));
        end
        icount += 33;
    endtask

    // ------------------------------
    // Store trace checker
    // ------------------------------
    always @(posedge clk) begin
        if (rst_n && st_valid) begin
            if (n_stores >= exp_addr.size()) begin
                $display("Unexpected extra store to address %h", st_addr);
                errs[2]++;
                trace_errs++;
            end else begin
                cur_test = exp_test[n_stores];
                if (st_addr !== exp_addr[n_stores]) begin
                    $display("ERR %s store %0d addr expected %h actual %h",
                             names[cur_test], n_stores, exp_addr[n_stores], st_addr);
                    errs[cur_test]++;
                    trace_errs++;
                end
                if (st_data !== exp_data[n_stores]) begin
                    $display("ERR %s store %0d data expected %h actual %h",
                             names[cur_test], n_stores, exp_data[n_stores], st_data);
                    errs[cur_test]++;
                    trace_errs++;
                end
            end
            n_stores++;
        end
    end

    initial begin
        names[0] = "alu_dependent";
        names[1] = "load_use";
        names[2] = "store_trace";
        names[3] = "branch";
        names[4] = "x0_and_halt";
        for (int i = 0; i < 5; i++) errs[i] = 0;
        seed = 9;
        n_taken = 0;
        n_not_taken = 0;
        n_stores = 0;
        trace_errs = 0;
        rst_n = 1'b0;
        imem_load_we = 1'b0;
        imem_load_addr = '0;
        imem_load_data = '0;
        dmem_load_we = 1'b0;
        dmem_load_addr = '0;
        dmem_load_data = '0;
        build_program();
        run_model();

        // Preload both RAMs while in reset
        n_load = (prog.size() > data_words) ? prog.size() : data_words;
        for (int i = 0; i < n_load; i++) begin
            @(posedge clk);
            imem_load_we   <= (i < prog.size());
            imem_load_addr <= 32'(4 * i);
            imem_load_data <= (i < prog.size()) ? prog[i] : '0;
            dmem_load_we   <= (i < data_words);
            dmem_load_addr <= 32'(4 * i);
            dmem_load_data <= (i < data_words) ? init_data[i] : '0;
        end
        @(posedge clk);
        imem_load_we <= 1'b0;
        dmem_load_we <= 1'b0;
        repeat (15) @(posedge clk);
        rst_n <= 1'b1;

        // Bounded wait for halted
        limit = 8 * icount + 100;
        cycles = 0;
        while (!halted && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        @(posedge clk);

        if (!halted) begin
            $display("halted did not rise within %0d cycles", limit);
            errs[4]++;
        end
        if (n_stores != exp_addr.size()) begin
            $display("ERR x0_and_halt store count expected %0d actual %0d",
                     exp_addr.size(), n_stores);
            errs[4]++;
        end
        if (n_taken == 0 || n_not_taken == 0) begin
            $display("Program lacks a taken or a not-taken branch");
            errs[3]++;
        end
        // A store from a skipped instruction shifts the whole trace
        if (trace_errs != 0 || n_stores != exp_addr.size()) begin
            $display("Store trace around branches does not match the model");
            errs[3]++;
        end

        total = 0;
        for (int i = 0; i < 5; i++) begin
            $display("%-14s %s, %0d errors", names[i], (errs[i] == 0) ? "ok" : "FAILED", errs[i]);
            if (errs[i] != 0) total++;
        end
        $display("%0d of 5 tests ok, %0d stores seen, %0d cycles", 5 - total, n_stores, cycles);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* rv_pipe.f */
hw/rv_pipe_pkg.sv
hw/mem_bus.sv
hw/word_ram.sv
hw/regfile.sv
hw/decoder.sv
hw/alu.sv
hw/hazard_unit.sv
hw/cpu.sv
hw/rv_pipe_top.sv
tests/rv_pipe_assertions.sv
tests/rv_pipe_tb.sv

/* run_rv_pipe.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f rv_pipe.f \
    --top-module rv_pipe_tb -Mdir obj_rv_pipe
./obj_rv_pipe/Vrv_pipe_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log || ! grep -q "test passed" sim.log; then
    exit 1
fi
exit 0
